//--- design/controlPkg.sv
package controlPkg;

    // Instruction field widths
    parameter int OpcodeWidth = 6;
    parameter int FunctWidth = 6;

    // Primary opcode of the kept instructions
    typedef enum logic [OpcodeWidth-1:0] {
        rType     = 6'b000000,
        j         = 6'b000010,
        beq       = 6'b000100,
        bne       = 6'b000101,
        addi      = 6'b001000,
        haltReset = 6'b111111
    } opcodeT;

    // Funct field, only meaningful under rType
    typedef enum logic [FunctWidth-1:0] {
        functAdd = 6'b100000,
        functSub = 6'b100010,
        functAnd = 6'b100100
    } functT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluAnd
    } aluOpT;

    // What the execute step has to do
    typedef enum logic [2:0] {
        classAlu,
        classAddi,
        classBeq,
        classBne,
        classJump,
        classHalt,
        classIllegal
    } instrClassT;

    // Sequencer steps
    typedef enum logic [2:0] {
        stReset,
        stFetch,
        stLoadIr,
        stDecode,
        stExecute,
        stWriteBack,
        stError,
        stHalt
    } stateT;

    typedef enum logic [1:0] {
        srcRegB,
        srcFour,
        srcImmediate
    } aluSrcBT;

    typedef enum logic {
        dstRt,
        dstRd
    } regDstT;

    // Next PC source
    typedef enum logic [1:0] {
        pcAluResult,
        pcBranchTarget,
        pcJumpTarget
    } pcSrcT;

endpackage

//--- design/instructionDecoder.sv
module instructionDecoder (
    input  logic                   clock,
    input  logic                   reset,
    input  controlPkg::opcodeT     opcode,
    input  controlPkg::functT      funct,
    output controlPkg::instrClassT instrClass,
    output controlPkg::aluOpT      decodedAluOp
);
    import controlPkg::*;

    instrClassT nextClass;
    aluOpT      nextAluOp;

    always_comb begin
        nextClass = classIllegal;
        nextAluOp = aluAdd;
        case (opcode)
            rType: begin
                // Funct picks the ALU operation
                case (funct)
                    functAdd: begin
                        nextClass = classAlu;
                        nextAluOp = aluAdd;
                    end
                    functSub: begin
                        nextClass = classAlu;
                        nextAluOp = aluSub;
                    end
                    functAnd: begin
                        nextClass = classAlu;
                        nextAluOp = aluAnd;
                    end
                    default: begin
                        nextClass = classIllegal;
                    end
                endcase
            end
            addi: begin
                nextClass = classAddi;
                nextAluOp = aluAdd;
            end
            beq: begin
                nextClass = classBeq;
                nextAluOp = aluSub;
            end
            bne: begin
                nextClass = classBne;
                nextAluOp = aluSub;
            end
            j: begin
                nextClass = classJump;
            end
            haltReset: begin
                nextClass = classHalt;
            end
            default: begin
                nextClass = classIllegal;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            instrClass   <= classAlu;
            decodedAluOp <= aluAdd;
        end else begin
            instrClass   <= nextClass;
            decodedAluOp <= nextAluOp;
        end
    end

endmodule

//--- design/stepSequencer.sv
module stepSequencer #(
    parameter int MemWaitCycles = 3
) (
    input  logic                   clock,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    output controlPkg::stateT      state,
    output controlPkg::instrClassT execClass
);
    import controlPkg::*;

    // Last beat of the memory wait
    localparam logic [2:0] LastFetchStep = 3'(MemWaitCycles - 1);

    // Opcode arrives the beat after the IR load, then the decoder registers it
    localparam logic [2:0] LastDecodeStep = 3'd2;

    logic [2:0] stepCount;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= stReset;
            stepCount <= '0;
            execClass <= classAlu;
        end else begin
            case (state)
                // Leaving reset already counts as the first wait beat
                stReset, stFetch: begin
                    if (stepCount == LastFetchStep) begin
                        state     <= stLoadIr;
                        stepCount <= '0;
                    end else begin
                        state     <= stFetch;
                        stepCount <= stepCount + 3'd1;
                    end
                end

                stLoadIr: begin
                    state     <= stDecode;
                    stepCount <= '0;
                end

                stDecode: begin
                    if (stepCount == LastDecodeStep) begin
                        stepCount <= '0;
                        execClass <= instrClass;
                        case (instrClass)
                            classIllegal: begin
                                state <= stError;
                            end
                            classHalt: begin
                                state <= stHalt;
                            end
                            default: begin
                                state <= stExecute;
                            end
                        endcase
                    end else begin
                        state     <= stDecode;
                        stepCount <= stepCount + 3'd1;
                    end
                end

                stExecute: begin
                    // Only register results need a write-back beat
                    if (execClass == classAlu || execClass == classAddi) begin
                        state <= stWriteBack;
                    end else begin
                        state <= stFetch;
                    end
                    stepCount <= '0;
                end

                stWriteBack: begin
                    state     <= stFetch;
                    stepCount <= '0;
                end

                stError: begin
                    state     <= stFetch;
                    stepCount <= '0;
                end

                // Only reset gets out of here
                stHalt: begin
                    state     <= stHalt;
                    stepCount <= '0;
                end
            endcase
        end
    end

endmodule

//--- design/controlWordGen.sv
module controlWordGen (
    input  logic                   clock,
    input  logic                   reset,
    input  controlPkg::stateT      state,
    input  controlPkg::instrClassT execClass,
    input  controlPkg::aluOpT      decodedAluOp,
    input  logic                   zero,
    output logic                   pcWrite,
    output logic                   pcWriteCond,
    output logic                   memRead,
    output logic                   irWrite,
    output logic                   abWrite,
    output logic                   aluOutWrite,
    output logic                   regWrite,
    output logic                   opcodeError,
    output logic                   resetOut,
    output controlPkg::aluOpT      aluOp,
    output logic                   aluSrcA,
    output controlPkg::aluSrcBT    aluSrcB,
    output controlPkg::regDstT     regDst,
    output controlPkg::pcSrcT      pcSrc
);
    import controlPkg::*;

    logic    nextPcWrite;
    logic    nextPcWriteCond;
    logic    nextMemRead;
    logic    nextIrWrite;
    logic    nextAbWrite;
    logic    nextAluOutWrite;
    logic    nextRegWrite;
    logic    nextOpcodeError;
    logic    nextResetOut;
    aluOpT   nextAluOp;
    logic    nextAluSrcA;
    aluSrcBT nextAluSrcB;
    regDstT  nextRegDst;
    pcSrcT   nextPcSrc;

    always_comb begin
        nextPcWrite     = 1'b0;
        nextPcWriteCond = 1'b0;
        nextMemRead     = 1'b0;
        nextIrWrite     = 1'b0;
        nextAbWrite     = 1'b0;
        nextAluOutWrite = 1'b0;
        nextRegWrite    = 1'b0;
        nextOpcodeError = 1'b0;
        nextResetOut    = 1'b0;
        nextAluOp       = aluAdd;
        nextAluSrcA     = 1'b0;
        nextAluSrcB     = srcRegB;
        nextRegDst      = dstRt;
        nextPcSrc       = pcAluResult;
        case (state)
            // PC + 4 while memory answers
            stReset, stFetch: begin
                nextMemRead = 1'b1;
                nextAluSrcB = srcFour;
            end
            stLoadIr: begin
                nextMemRead = 1'b1;
                nextPcWrite = 1'b1;
                nextIrWrite = 1'b1;
                nextAluSrcB = srcFour;
            end
            // A and B load on the first decode beat only, right behind the IR load
            stDecode: begin
                nextAbWrite = irWrite;
            end
            stExecute: begin
                case (execClass)
                    classAlu, classAddi: begin
                        nextAluOutWrite = 1'b1;
                        nextAluOp       = decodedAluOp;
                        nextAluSrcA     = 1'b1;
                        nextAluSrcB     = (execClass == classAddi) ? srcImmediate : srcRegB;
                    end
                    classBeq, classBne: begin
                        nextAluOp   = decodedAluOp;
                        nextAluSrcA = 1'b1;
                        nextAluSrcB = srcRegB;
                        nextPcSrc   = pcBranchTarget;
                        // Taken on equal for beq, on not equal for bne
                        nextPcWriteCond = (execClass == classBeq) ? zero : !zero;
                    end
                    classJump: begin
                        nextPcWrite = 1'b1;
                        nextPcSrc   = pcJumpTarget;
                    end
                    default: begin
                        nextPcWrite = 1'b0;
                    end
                endcase
            end
            stWriteBack: begin
                nextRegWrite = 1'b1;
                nextRegDst   = (execClass == classAlu) ? dstRd : dstRt;
            end
            stError: begin
                nextOpcodeError = 1'b1;
            end
            stHalt: begin
                nextResetOut = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            pcWriteCond <= 1'b0;
            memRead     <= 1'b0;
            irWrite     <= 1'b0;
            abWrite     <= 1'b0;
            aluOutWrite <= 1'b0;
            regWrite    <= 1'b0;
            opcodeError <= 1'b0;
            resetOut    <= 1'b1;
            aluOp       <= aluAdd;
            aluSrcA     <= 1'b0;
            aluSrcB     <= srcRegB;
            regDst      <= dstRt;
            pcSrc       <= pcAluResult;
        end else begin
            pcWrite     <= nextPcWrite;
            pcWriteCond <= nextPcWriteCond;
            memRead     <= nextMemRead;
            irWrite     <= nextIrWrite;
            abWrite     <= nextAbWrite;
            aluOutWrite <= nextAluOutWrite;
            regWrite    <= nextRegWrite;
            opcodeError <= nextOpcodeError;
            resetOut    <= nextResetOut;
            aluOp       <= nextAluOp;
            aluSrcA     <= nextAluSrcA;
            aluSrcB     <= nextAluSrcB;
            regDst      <= nextRegDst;
            pcSrc       <= nextPcSrc;
        end
    end

endmodule

//--- design/controlUnit.sv
module controlUnit #(
    parameter int MemWaitCycles = 3
) (
    input  logic                clock,
    input  logic                reset,
    input  controlPkg::opcodeT  opcode,
    input  controlPkg::functT   funct,
    input  logic                zero,
    output logic                pcWrite,
    output logic                pcWriteCond,
    output logic                memRead,
    output logic                irWrite,
    output logic                abWrite,
    output logic                aluOutWrite,
    output logic                regWrite,
    output logic                opcodeError,
    output logic                resetOut,
    output controlPkg::aluOpT   aluOp,
    output logic                aluSrcA,
    output controlPkg::aluSrcBT aluSrcB,
    output controlPkg::regDstT  regDst,
    output controlPkg::pcSrcT   pcSrc
);
    import controlPkg::*;

    instrClassT instrClass;
    aluOpT      decodedAluOp;
    stateT      state;
    instrClassT execClass;

    instructionDecoder decoder (
        .clock        (clock),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .instrClass   (instrClass),
        .decodedAluOp (decodedAluOp)
    );

    stepSequencer #(
        .MemWaitCycles (MemWaitCycles)
    ) sequencer (
        .clock      (clock),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state),
        .execClass  (execClass)
    );

    controlWordGen wordGen (
        .clock        (clock),
        .reset        (reset),
        .state        (state),
        .execClass    (execClass),
        .decodedAluOp (decodedAluOp),
        .zero         (zero),
        .pcWrite      (pcWrite),
        .pcWriteCond  (pcWriteCond),
        .memRead      (memRead),
        .irWrite      (irWrite),
        .abWrite      (abWrite),
        .aluOutWrite  (aluOutWrite),
        .regWrite     (regWrite),
        .opcodeError  (opcodeError),
        .resetOut     (resetOut),
        .aluOp        (aluOp),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .regDst       (regDst),
        .pcSrc        (pcSrc)
    );

endmodule

//--- tests/controlUnitTb.sv
module controlUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import controlPkg::*;

    localparam int MemWaitCycles = 3;
    localparam int MaxLines = 32;
    localparam int LineTimeout = 40;
    localparam int HaltWindow = 20;

    // Golden columns
    localparam int ColOpcode = 0;
    localparam int ColFunct = 1;
    localparam int ColZero = 2;
    localparam int ColLength = 3;
    localparam int ColRegWrite = 4;
    localparam int ColPcWriteCond = 5;
    localparam int ColPcWrite = 6;
    localparam int ColOpcodeError = 7;
    localparam int ColAluOp = 8;
    localparam int ColRegDst = 9;

    logic    clock;
    logic    reset;
    opcodeT  opcode;
    functT   funct;
    logic    zero;
    logic    pcWrite;
    logic    pcWriteCond;
    logic    memRead;
    logic    irWrite;
    logic    abWrite;
    logic    aluOutWrite;
    logic    regWrite;
    logic    opcodeError;
    logic    resetOut;
    aluOpT   aluOp;
    logic    aluSrcA;
    aluSrcBT aluSrcB;
    regDstT  regDst;
    pcSrcT   pcSrc;

    int golden[MaxLines][10];
    int lineCount;
    int errorCount;

    controlUnit #(
        .MemWaitCycles (MemWaitCycles)
    ) DUT (
        .clock       (clock),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .zero        (zero),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .memRead     (memRead),
        .irWrite     (irWrite),
        .abWrite     (abWrite),
        .aluOutWrite (aluOutWrite),
        .regWrite    (regWrite),
        .opcodeError (opcodeError),
        .resetOut    (resetOut),
        .aluOp       (aluOp),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .regDst      (regDst),
        .pcSrc       (pcSrc)
    );

    always #20 clock = ~clock;

    task automatic stopOnFailure(input string reason);
        errorCount++;
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        if (expected != actual) begin
            stopOnFailure($sformatf("FAILED at %0t ns: %s, expected %0d, got %0d",
                $time, what, expected, actual));
        end
    endtask

    // Step to 1 ns past the next rising edge
    task automatic stepCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic randomizeFields();
        opcode = opcodeT'(6'($urandom()));
        funct = functT'(6'($urandom()));
    endtask

    task automatic driveInstruction(input int idx);
        opcode = opcodeT'(6'(golden[idx][ColOpcode]));
        funct = functT'(6'(golden[idx][ColFunct]));
        // 2 marks a zero that nothing looks at
        if (golden[idx][ColZero] > 1)
            zero = 1'($urandom());
        else
            zero = 1'(golden[idx][ColZero]);
    endtask

    task automatic readGolden();
        int fd;
        int status;
        string lineText;
        fd = $fopen("tests/controlUnitGolden.txt", "r");
        if (fd == 0)
            stopOnFailure("Could not open the golden file tests/controlUnitGolden.txt");
        lineCount = 0;
        while (!$feof(fd) && lineCount < MaxLines) begin
            lineText = "";
            status = $fgets(lineText, fd);
            if (status > 0 && lineText.substr(0, 1) != "//") begin
                status = $sscanf(lineText, "%h %h %d %d %d %d %d %d %d %d",
                    golden[lineCount][0], golden[lineCount][1], golden[lineCount][2],
                    golden[lineCount][3], golden[lineCount][4], golden[lineCount][5],
                    golden[lineCount][6], golden[lineCount][7], golden[lineCount][8],
                    golden[lineCount][9]);
                if (status == 10)
                    lineCount++;
            end
        end
        $fclose(fd);
        if (lineCount == 0)
            stopOnFailure("The golden file holds no instruction lines");
    endtask

    task automatic checkControlsOff(input string phase);
        checkValue({phase, ": controls"}, 0,
            {pcWrite, pcWriteCond, memRead, irWrite, abWrite, aluOutWrite, regWrite, opcodeError,
                aluSrcA});
        checkValue({phase, ": resetOut"}, 1, resetOut);
    endtask

    task automatic applyReset();
        reset = 1'b1;
        randomizeFields();
        repeat (2) begin
            stepCycle();
            checkControlsOff("reset");
            checkValue("reset: aluOp", int'(aluAdd), aluOp);
            checkValue("reset: aluSrcB", int'(srcRegB), aluSrcB);
            checkValue("reset: regDst", int'(dstRt), regDst);
            checkValue("reset: pcSrc", int'(pcAluResult), pcSrc);
        end
        reset = 1'b0;
    endtask

    // From reset release up to the first irWrite
    task automatic startFetch();
        int memOnly;
        int beats;
        stepCycle();
        checkValue("memRead on the first cycle after reset", 1, memRead);
        checkValue("resetOut after reset", 0, resetOut);
        memOnly = 1;
        beats = 1;
        while (irWrite !== 1'b1) begin
            stepCycle();
            beats++;
            if (beats > LineTimeout)
                stopOnFailure($sformatf("Timeout at %0t ns: no irWrite after reset", $time));
            if (memRead && !irWrite)
                memOnly++;
        end
        checkValue("memRead cycles before the first irWrite", MemWaitCycles, memOnly);
    endtask

    // Starts on an irWrite cycle and ends on the next one
    task automatic runInstruction(input int idx);
        int beats;
        int memOnly;
        int abCount;
        int aluOutCount;
        int regWriteCount;
        int condCount;
        int pcWriteCount;
        int errorPulses;
        int execAluOp;
        int wbRegDst;
        int execBeat;
        logic prevAluOut;
        logic done;
        aluSrcBT expectedSrcB;
        pcSrcT expectedPcSrc;
        string tag;
        tag = $sformatf("instruction %0d", idx + 1);
        checkValue({tag, ": pcWrite with irWrite"}, 1, pcWrite);
        checkValue({tag, ": memRead with irWrite"}, 1, memRead);
        expectedSrcB = (golden[idx][ColOpcode] == int'(addi)) ? srcImmediate : srcRegB;
        if (golden[idx][ColOpcode] == int'(beq) || golden[idx][ColOpcode] == int'(bne))
            expectedPcSrc = pcBranchTarget;
        else if (golden[idx][ColOpcode] == int'(j))
            expectedPcSrc = pcJumpTarget;
        else
            expectedPcSrc = pcAluResult;
        // Execute sits before the write-back beat and the memory wait
        execBeat = golden[idx][ColLength] - MemWaitCycles - golden[idx][ColRegWrite];
        beats = 1;
        memOnly = 0;
        abCount = 0;
        aluOutCount = 0;
        regWriteCount = 0;
        condCount = 0;
        pcWriteCount = 0;
        errorPulses = 0;
        execAluOp = int'(aluAdd);
        wbRegDst = int'(dstRt);
        prevAluOut = 1'b0;
        done = 1'b0;
        while (!done) begin
            stepCycle();
            // IR holds the new instruction from the cycle after irWrite
            if (beats == 1)
                driveInstruction(idx);
            if (irWrite) begin
                done = 1'b1;
            end else begin
                beats++;
                if (beats > LineTimeout)
                    stopOnFailure($sformatf("Timeout at %0t ns: %s never reached the next irWrite",
                        $time, tag));
                if (beats == 2)
                    checkValue({tag, ": abWrite after irWrite"}, 1, abWrite);
                if (memRead) begin
                    memOnly++;
                    checkValue({tag, ": aluSrcB in fetch"}, int'(srcFour), aluSrcB);
                    checkValue({tag, ": aluOp in fetch"}, int'(aluAdd), aluOp);
                end
                if (aluOutWrite)
                    checkValue({tag, ": aluSrcB on aluOutWrite"}, int'(expectedSrcB), aluSrcB);
                if (regWrite) begin
                    checkValue({tag, ": aluOutWrite right before regWrite"}, 1, prevAluOut);
                    wbRegDst = int'(regDst);
                end
                if (beats == execBeat) begin
                    execAluOp = int'(aluOp);
                    checkValue({tag, ": pcSrc in execute"}, int'(expectedPcSrc), pcSrc);
                end
                checkValue({tag, ": resetOut"}, 0, resetOut);
                abCount += abWrite;
                aluOutCount += aluOutWrite;
                regWriteCount += regWrite;
                condCount += pcWriteCond;
                pcWriteCount += pcWrite;
                errorPulses += opcodeError;
                prevAluOut = aluOutWrite;
            end
        end
        checkValue({tag, ": length"}, golden[idx][ColLength], beats);
        checkValue({tag, ": memRead-only cycles"}, MemWaitCycles, memOnly);
        checkValue({tag, ": abWrite pulses"}, 1, abCount);
        checkValue({tag, ": aluOutWrite pulses"}, golden[idx][ColRegWrite], aluOutCount);
        checkValue({tag, ": regWrite pulses"}, golden[idx][ColRegWrite], regWriteCount);
        checkValue({tag, ": pcWriteCond pulses"}, golden[idx][ColPcWriteCond], condCount);
        checkValue({tag, ": pcWrite in execute"}, golden[idx][ColPcWrite], pcWriteCount);
        checkValue({tag, ": opcodeError pulses"}, golden[idx][ColOpcodeError], errorPulses);
        checkValue({tag, ": aluOp in execute"}, golden[idx][ColAluOp], execAluOp);
        checkValue({tag, ": regDst on write-back"}, golden[idx][ColRegDst], wbRegDst);
    endtask

    task automatic runHalt(input int idx);
        int beats;
        string tag;
        tag = $sformatf("instruction %0d", idx + 1);
        beats = 0;
        while (resetOut !== 1'b1) begin
            stepCycle();
            beats++;
            if (beats == 1)
                driveInstruction(idx);
            if (beats > LineTimeout)
                stopOnFailure($sformatf("Timeout at %0t ns: resetOut did not rise after halt",
                    $time));
            checkValue({tag, ": irWrite before halt"}, 0, irWrite);
        end
        repeat (HaltWindow) begin
            stepCycle();
            checkControlsOff({tag, ": halted"});
        end
    endtask

    initial begin
        int idx;
        void'($urandom(32'h0b56_fc53));
        errorCount = 0;
        clock = 1'b0;
        reset = 1'b1;
        zero = 1'($urandom());
        randomizeFields();
        readGolden();
        applyReset();
        startFetch();
        for (idx = 0; idx < lineCount; idx++) begin
            if (golden[idx][ColLength] == 0) begin
                runHalt(idx);
                applyReset();
                startFetch();
            end else begin
                runInstruction(idx);
            end
        end
        if (errorCount == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

//--- tests/controlUnitGolden.txt
// opcode(hex) funct(hex) zero(2 = any) length(0 = halt) regWrite pcWriteCond pcWrite opcodeError
// aluOp(0 add, 1 sub, 2 and) regDst(0 rt, 1 rd); counts are pulses between two irWrite pulses
00 20 2 9 1 0 0 0 0 1 add
00 22 2 9 1 0 0 0 1 1 sub
00 24 2 9 1 0 0 0 2 1 and
08 15 2 9 1 0 0 0 0 0 addi
04 00 1 8 0 1 0 0 1 0 beq taken
04 00 0 8 0 0 0 0 1 0 beq not taken
05 00 0 8 0 1 0 0 1 0 bne taken
05 00 1 8 0 0 0 0 1 0 bne not taken
02 2a 2 8 0 0 1 0 0 0 j
3a 20 2 8 0 0 0 1 0 0 unknown opcode
00 3f 2 8 0 0 0 1 0 0 unknown funct
00 22 2 9 1 0 0 0 1 1 sub after error
3f 00 2 0 0 0 0 0 0 0 halt
08 07 2 9 1 0 0 0 0 0 addi after reset
04 00 1 8 0 1 0 0 1 0 beq taken
00 24 2 9 1 0 0 0 2 1 and

//--- project.f
design/controlPkg.sv
design/instructionDecoder.sv
design/stepSequencer.sv
design/controlWordGen.sv
design/controlUnit.sv
tests/controlUnitTb.sv
